// ==== source/exu_config.svh ====
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// data path and address width
`define XLEN 32

// register file index width
`define REG_AW 5

// global history bits kept by the predictor
`define HISLEN 8

// trap bus, passed through untouched
`define TRAP_LEN 8

// prediction statistics counters
`define CNT_W 32

// fixed step to the next sequential instruction
`define INST_STEP 4

// upper immediate keeps bits above this one
`define UIMM_LSB 12

`endif

// ==== source/exu_op_pkg.sv ====
`default_nettype none

package exu_op_pkg;

  // instruction class from decode
  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_OPREG  = 4'd1,
    EXC_OPIMM  = 4'd2,
    EXC_LOAD   = 4'd3,
    EXC_STORE  = 4'd4,
    EXC_BRANCH = 4'd5,
    EXC_JAL    = 4'd6,
    EXC_JALR   = 4'd7,
    EXC_LUI    = 4'd8,
    EXC_AUIPC  = 4'd9,
    EXC_EBREAK = 4'd10
  } exc_op_e;

  // arithmetic ops first, then the branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND,
    ALU_EQ,  ALU_NE,  ALU_LT,  ALU_GE,  ALU_LTU, ALU_GEU
  } alu_op_e;

  // load/store micro-op, only carried to MEM
  typedef enum logic [3:0] {
    MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
    MEM_SB,   MEM_SH, MEM_SW
  } mem_op_e;

  typedef enum logic [1:0] {
    PC_NONE   = 2'd0,
    PC_JUMP   = 2'd1,
    PC_BRANCH = 2'd2,
    PC_TRAP   = 2'd3
  } pc_op_e;

  // encoding matches the predictor's jump type field
  typedef enum logic [1:0] {
    JT_NONE   = 2'd0,
    JT_JAL    = 2'd1,
    JT_JALR   = 2'd2,
    JT_BRANCH = 2'd3
  } jump_type_e;

endpackage

`default_nettype wire

// ==== source/exu_bus_pkg.sv ====
`default_nettype none

`include "exu_config.svh"

package exu_bus_pkg;

  import exu_op_pkg::*;

  // decoded instruction at the ID/EX boundary
  typedef struct packed {
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     inst;
    logic [`REG_AW-1:0]   rd_idx;
    logic [`XLEN-1:0]     rs1_data;
    logic [`XLEN-1:0]     rs2_data;
    logic [`XLEN-1:0]     imm;
    exc_op_e              exc_op;
    alu_op_e              alu_op;
    mem_op_e              mem_op;
    pc_op_e               pc_op;
    logic [`TRAP_LEN-1:0] trap;
  } id_ex_bus_t;

  // prediction made at fetch for this pc
  typedef struct packed {
    logic               pdt_taken;
    logic               which_pdt;  // predictor that made the call
    logic [`HISLEN-1:0] history;
    logic [`XLEN-1:0]   pdt_tag;    // pc the prediction belongs to
  } pdt_info_t;

  typedef struct packed {
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     inst;
    logic [`REG_AW-1:0]   rd_idx;
    logic [`XLEN-1:0]     rs2_data;  // store data
    logic [`XLEN-1:0]     imm;
    logic [`XLEN-1:0]     alu_res;
    mem_op_e              mem_op;
    pc_op_e               pc_op;
    exc_op_e              exc_op;
    logic [`TRAP_LEN-1:0] trap;
  } ex_mem_bus_t;

  // resolved outcome back to the predictor
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    logic               taken;
    logic               correct;
    jump_type_e         jump_type;
    logic               which_pdt;
    logic [`HISLEN-1:0] history;
    logic [`REG_AW-1:0] rd_idx;  // lets the predictor spot calls and returns
  } bpu_update_t;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

// ==== source/operand_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module operand_mux
  import exu_op_pkg::*;
  import exu_bus_pkg::*;
(
  input  id_ex_bus_t       id_ex_i,
  output logic [`XLEN-1:0] alu_a_o,
  output logic [`XLEN-1:0] alu_b_o
);

  logic             sel_rs1_rs2;   // register-register and branch compare
  logic             sel_rs1_imm;   // op-imm and address generation
  logic             sel_pc_4;      // link address of jumps
  logic             sel_pc_uimm;   // auipc
  logic             sel_zero_uimm; // lui
  logic [`XLEN-1:0] uimm;

  assign sel_rs1_rs2   = (id_ex_i.exc_op == EXC_OPREG) || (id_ex_i.exc_op == EXC_BRANCH);
  assign sel_rs1_imm   = (id_ex_i.exc_op == EXC_OPIMM) || (id_ex_i.exc_op == EXC_LOAD) ||
                         (id_ex_i.exc_op == EXC_STORE);
  assign sel_pc_4      = (id_ex_i.exc_op == EXC_JAL) || (id_ex_i.exc_op == EXC_JALR);
  assign sel_pc_uimm   = (id_ex_i.exc_op == EXC_AUIPC);
  assign sel_zero_uimm = (id_ex_i.exc_op == EXC_LUI);

  // upper immediate with the low part cleared
  assign uimm = {id_ex_i.imm[`XLEN-1:`UIMM_LSB], {`UIMM_LSB{1'b0}}};

  // lui leaves operand a at zero, so no term for it
  assign alu_a_o = ({`XLEN{sel_rs1_rs2 | sel_rs1_imm}} & id_ex_i.rs1_data) |
                   ({`XLEN{sel_pc_4 | sel_pc_uimm}}    & id_ex_i.pc);

  assign alu_b_o = ({`XLEN{sel_rs1_rs2}}                 & id_ex_i.rs2_data) |
                   ({`XLEN{sel_rs1_imm}}                 & id_ex_i.imm) |
                   ({`XLEN{sel_pc_4}}                    & `XLEN'(`INST_STEP)) |
                   ({`XLEN{sel_pc_uimm | sel_zero_uimm}} & uimm);

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module alu
  import exu_op_pkg::*;
(
  input  logic [`XLEN-1:0] a_i,
  input  logic [`XLEN-1:0] b_i,
  input  alu_op_e          op_i,
  output logic [`XLEN-1:0] res_o,
  output logic             cmp_o
);

  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] diff;
  logic [4:0]       shamt;
  logic             eq;
  logic             lt_s;
  logic             lt_u;

  assign sum   = a_i + b_i;
  assign diff  = a_i - b_i;
  assign shamt = b_i[4:0];  // rv32 shifts use 5 bits

  assign eq   = (a_i == b_i);
  assign lt_s = ($signed(a_i) < $signed(b_i));
  assign lt_u = (a_i < b_i);

  always_comb begin
    res_o = sum;  // compares leave the adder on the result
    cmp_o = 1'b0;
    case (op_i)
      ALU_ADD:  res_o = sum;
      ALU_SUB:  res_o = diff;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SLT:  res_o = {{(`XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: res_o = {{(`XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:   res_o = a_i | b_i;
      ALU_AND:  res_o = a_i & b_i;

      // branch conditions
      ALU_EQ:   cmp_o = eq;
      ALU_NE:   cmp_o = !eq;
      ALU_LT:   cmp_o = lt_s;
      ALU_GE:   cmp_o = !lt_s;
      ALU_LTU:  cmp_o = lt_u;
      ALU_GEU:  cmp_o = !lt_u;
      default: begin
        res_o = sum;
        cmp_o = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module branch_resolve
  import exu_op_pkg::*;
  import exu_bus_pkg::*;
(
  input  logic        valid_i,
  input  logic        stall_i,
  input  id_ex_bus_t  id_ex_i,
  input  pdt_info_t   pdt_i,
  input  logic        cmp_i,
  output redirect_t   redirect_o,
  output bpu_update_t upd_o,
  output logic        upd_valid_o
);

  logic             is_branch;
  logic             is_jal;
  logic             is_jalr;
  logic             is_cf;
  logic             taken;
  logic             pdt_eff;
  logic             mispredict;
  logic             fire;
  logic             fall_back;
  logic [`XLEN-1:0] tgt_op1;
  logic [`XLEN-1:0] tgt_op2;
  logic [`XLEN-1:0] tgt_sum;
  jump_type_e       jump_type;

  assign is_branch = (id_ex_i.exc_op == EXC_BRANCH);
  assign is_jal    = (id_ex_i.exc_op == EXC_JAL);
  assign is_jalr   = (id_ex_i.exc_op == EXC_JALR);
  assign is_cf     = is_branch | is_jal | is_jalr;

  assign taken = is_jal | is_jalr | (is_branch & cmp_i);

  // a prediction only counts when its tag hits this pc
  assign pdt_eff    = pdt_i.pdt_taken & (pdt_i.pdt_tag == id_ex_i.pc);
  assign mispredict = (taken != pdt_eff);

  // predicted taken but falls through, go back to the next pc
  assign fall_back = pdt_eff & ~taken;

  // one adder serves all three targets
  assign tgt_op1 = (is_jalr && !fall_back) ? id_ex_i.rs1_data : id_ex_i.pc;
  assign tgt_op2 = fall_back ? `XLEN'(`INST_STEP) : id_ex_i.imm;
  assign tgt_sum = tgt_op1 + tgt_op2;

  always_comb begin
    case (1'b1)
      is_jal:    jump_type = JT_JAL;
      is_jalr:   jump_type = JT_JALR;
      is_branch: jump_type = JT_BRANCH;
      default:   jump_type = JT_NONE;
    endcase
  end

  assign fire = valid_i & ~stall_i;  // instruction leaves EX this cycle

  assign redirect_o.valid  = fire & mispredict;
  assign redirect_o.target = {tgt_sum[`XLEN-1:1], tgt_sum[0] & ~is_jalr}; // jalr drops bit 0

  assign upd_valid_o     = fire & is_cf;
  assign upd_o.pc        = id_ex_i.pc;
  assign upd_o.taken     = taken;
  assign upd_o.correct   = ~mispredict;
  assign upd_o.jump_type = jump_type;
  assign upd_o.which_pdt = pdt_i.which_pdt;
  assign upd_o.history   = pdt_i.history;
  assign upd_o.rd_idx    = id_ex_i.rd_idx;

endmodule

`default_nettype wire

// ==== source/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     en_i,     // low holds the stage
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (en_i) begin
      valid_q <= valid_i;  // bubble when nothing comes in
    end
  end

  // payload cleared too, so the downstream sees zeros after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_q <= '0;
    end else if (en_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

// ==== source/pred_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module pred_stats (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              upd_valid_i,  // one per resolved jump or branch
  input  logic              correct_i,
  output logic [`CNT_W-1:0] branch_cnt_o,
  output logic [`CNT_W-1:0] correct_cnt_o
);

  logic [`CNT_W-1:0] branch_q;
  logic [`CNT_W-1:0] correct_q;
  logic              branch_full;
  logic              correct_full;

  assign branch_full  = &branch_q;
  assign correct_full = &correct_q;

  // both counters stick at all ones
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      branch_q <= '0;
    end else if (upd_valid_i && !branch_full) begin
      branch_q <= branch_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      correct_q <= '0;
    end else if (upd_valid_i && correct_i && !correct_full) begin
      correct_q <= correct_q + 1'b1;
    end
  end

  assign branch_cnt_o  = branch_q;
  assign correct_cnt_o = correct_q;

endmodule

`default_nettype wire

// ==== source/exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module exu_top
  import exu_bus_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  logic              stall_i,    // memory stall
  input  id_ex_bus_t        id_ex_i,
  input  pdt_info_t         pdt_i,
  output ex_mem_bus_t       ex_mem_o,
  output logic              ex_mem_valid_o,
  output bpu_update_t       bpu_upd_o,
  output logic              bpu_upd_valid_o,
  output redirect_t         redirect_o,
  output logic [`XLEN-1:0]  alu_fwd_o,  // same-cycle result back to ID
  output logic [`CNT_W-1:0] branch_cnt_o,
  output logic [`CNT_W-1:0] correct_cnt_o
);

  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  logic [`XLEN-1:0] alu_res;
  logic             cmp_res;
  bpu_update_t      upd;
  logic             upd_valid;
  ex_mem_bus_t      ex_mem_d;

  operand_mux operand_mux_inst (.id_ex_i(id_ex_i), .alu_a_o(alu_a), .alu_b_o(alu_b));

  alu alu_inst (
    .a_i  (alu_a),
    .b_i  (alu_b),
    .op_i (id_ex_i.alu_op),
    .res_o(alu_res),
    .cmp_o(cmp_res)
  );

  branch_resolve branch_resolve_inst (
    .valid_i    (valid_i),
    .stall_i    (stall_i),
    .id_ex_i    (id_ex_i),
    .pdt_i      (pdt_i),
    .cmp_i      (cmp_res),
    .redirect_o (redirect_o),
    .upd_o      (upd),
    .upd_valid_o(upd_valid)
  );

  always_comb begin
    ex_mem_d.pc       = id_ex_i.pc;
    ex_mem_d.inst     = id_ex_i.inst;
    ex_mem_d.rd_idx   = id_ex_i.rd_idx;
    ex_mem_d.rs2_data = id_ex_i.rs2_data;
    ex_mem_d.imm      = id_ex_i.imm;
    ex_mem_d.alu_res  = alu_res;
    ex_mem_d.mem_op   = id_ex_i.mem_op;
    ex_mem_d.pc_op    = id_ex_i.pc_op;
    ex_mem_d.exc_op   = id_ex_i.exc_op;
    ex_mem_d.trap     = id_ex_i.trap;  // untouched here
  end

  pipe_reg #(.payload_t(ex_mem_bus_t)) ex_mem_reg_inst (
    .clk_i(clk_i), .rst_i(rst_i), .en_i(!stall_i),
    .valid_i(valid_i), .data_i(ex_mem_d),
    .valid_o(ex_mem_valid_o), .data_o(ex_mem_o)
  );

  pipe_reg #(.payload_t(bpu_update_t)) bpu_reg_inst (
    .clk_i(clk_i), .rst_i(rst_i), .en_i(!stall_i),
    .valid_i(upd_valid), .data_i(upd),
    .valid_o(bpu_upd_valid_o), .data_o(bpu_upd_o)
  );

  pred_stats pred_stats_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .upd_valid_i  (upd_valid),
    .correct_i    (upd.correct),
    .branch_cnt_o (branch_cnt_o),
    .correct_cnt_o(correct_cnt_o)
  );

  assign alu_fwd_o = alu_res;

endmodule

`default_nettype wire

// ==== test/tb_exu_vectors.svh ====
`ifndef TB_EXU_VECTORS_SVH
`define TB_EXU_VECTORS_SVH

// columns: class, alu op, pc, rs1, rs2, imm, predicted taken, prediction tag,
// then alu result, redirect valid, redirect target, update valid, taken, correct, jump type
typedef struct packed {
  exc_op_e          exc;
  alu_op_e          op;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] rs1;
  logic [`XLEN-1:0] rs2;
  logic [`XLEN-1:0] imm;
  logic             pdt;
  logic [`XLEN-1:0] tag;
  logic [`XLEN-1:0] res;
  logic             redir;
  logic [`XLEN-1:0] target;
  logic             upd;
  logic             taken;
  logic             correct;
  jump_type_e       jt;
} vec_t;

vec_t  vec_q[$];
string name_q[$];

function automatic void add_row(input string name, input exc_op_e exc, input alu_op_e op,
    input logic [`XLEN-1:0] pc, rs1, rs2, imm, input logic pdt, input logic [`XLEN-1:0] tag,
    input logic [`XLEN-1:0] res, input logic redir, input logic [`XLEN-1:0] target,
    input logic upd, taken, correct, input jump_type_e jt);
  vec_t v;
  v = '{exc, op, pc, rs1, rs2, imm, pdt, tag, res, redir, target, upd, taken, correct, jt};
  vec_q.push_back(v);
  name_q.push_back(name);
endfunction

// OPREG rows get random rs1/rs2 and a computed result at run time
task automatic load_vectors();
  add_row("addi", EXC_OPIMM, ALU_ADD, 32'h100, 32'h10, 32'hdead, 32'h7, 1'b0, 32'h0,
          32'h17, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("slti", EXC_OPIMM, ALU_SLT, 32'h104, 32'hfffffff0, 32'h0, 32'h3, 1'b0, 32'h0,
          32'h1, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("srai", EXC_OPIMM, ALU_SRA, 32'h108, 32'h80000000, 32'h0, 32'h4, 1'b0, 32'h0,
          32'hf8000000, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("slli_mask", EXC_OPIMM, ALU_SLL, 32'h10c, 32'h3, 32'h0, 32'h21, 1'b0, 32'h0,
          32'h6, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("load_addr", EXC_LOAD, ALU_ADD, 32'h110, 32'h1000, 32'h0, 32'h24, 1'b0, 32'h0,
          32'h1024, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("lui", EXC_LUI, ALU_ADD, 32'h114, 32'h1234, 32'h0, 32'habcde123, 1'b0, 32'h0,
          32'habcde000, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("auipc", EXC_AUIPC, ALU_ADD, 32'h400, 32'h0, 32'h0, 32'h00012fff, 1'b0, 32'h0,
          32'h12400, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("add_rnd", EXC_OPREG, ALU_ADD, 32'h120, 32'h0, 32'h0, 32'h0, 1'b0, 32'h0,
          32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("sub_rnd", EXC_OPREG, ALU_SUB, 32'h124, 32'h0, 32'h0, 32'h0, 1'b0, 32'h0,
          32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("sra_rnd", EXC_OPREG, ALU_SRA, 32'h128, 32'h0, 32'h0, 32'h0, 1'b0, 32'h0,
          32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("beq_t_nopdt", EXC_BRANCH, ALU_EQ, 32'h800, 32'h7, 32'h7, 32'h40, 1'b0, 32'h0,
          32'he, 1'b1, 32'h840, 1'b1, 1'b1, 1'b0, JT_BRANCH);
  add_row("bne_nt_pdt", EXC_BRANCH, ALU_NE, 32'h808, 32'h7, 32'h7, 32'h40, 1'b1, 32'h808,
          32'he, 1'b1, 32'h80c, 1'b1, 1'b0, 1'b0, JT_BRANCH);
  add_row("blt_t_pdt", EXC_BRANCH, ALU_LT, 32'h80c, 32'hffffffff, 32'h1, 32'hfffffff0, 1'b1,
          32'h80c, 32'h0, 1'b0, 32'h7fc, 1'b1, 1'b1, 1'b1, JT_BRANCH);
  add_row("bge_t_tagmiss", EXC_BRANCH, ALU_GE, 32'h810, 32'h5, 32'hffffffff, 32'h10, 1'b1,
          32'h900, 32'h4, 1'b1, 32'h820, 1'b1, 1'b1, 1'b0, JT_BRANCH);
  add_row("bltu_nt", EXC_BRANCH, ALU_LTU, 32'h814, 32'hffffffff, 32'h1, 32'h20, 1'b0, 32'h0,
          32'h0, 1'b0, 32'h834, 1'b1, 1'b0, 1'b1, JT_BRANCH);
  add_row("bgeu_t", EXC_BRANCH, ALU_GEU, 32'h818, 32'hffffffff, 32'h1, 32'hffffff00, 1'b0,
          32'h0, 32'h0, 1'b1, 32'h718, 1'b1, 1'b1, 1'b0, JT_BRANCH);
  add_row("addi_pdt_t", EXC_OPIMM, ALU_ADD, 32'he00, 32'h1, 32'h0, 32'h1, 1'b1, 32'he00,
          32'h2, 1'b1, 32'he04, 1'b0, 1'b0, 1'b0, JT_NONE);
  add_row("jal_nopdt", EXC_JAL, ALU_ADD, 32'ha00, 32'h123, 32'h0, 32'h100, 1'b0, 32'h0,
          32'ha04, 1'b1, 32'hb00, 1'b1, 1'b1, 1'b0, JT_JAL);
  add_row("jal_tagmiss", EXC_JAL, ALU_ADD, 32'ha08, 32'h0, 32'h0, 32'h20, 1'b1, 32'ha0c,
          32'ha0c, 1'b1, 32'ha28, 1'b1, 1'b1, 1'b0, JT_JAL);
  add_row("jalr_odd", EXC_JALR, ALU_ADD, 32'hc00, 32'h3001, 32'h0, 32'h4, 1'b0, 32'h0,
          32'hc04, 1'b1, 32'h3004, 1'b1, 1'b1, 1'b0, JT_JALR);
  // predictor update still valid when the stall starts
  add_row("jalr_pdt", EXC_JALR, ALU_ADD, 32'hc04, 32'h2000, 32'h0, 32'h10, 1'b1, 32'hc04,
          32'hc08, 1'b0, 32'h2010, 1'b1, 1'b1, 1'b1, JT_JALR);
  // last row is held by the stall test, not walked by the loop
  add_row("stall_beq", EXC_BRANCH, ALU_EQ, 32'hf00, 32'h9, 32'h9, 32'h80, 1'b0, 32'h0,
          32'h12, 1'b1, 32'hf80, 1'b1, 1'b1, 1'b0, JT_BRANCH);
endtask

`endif

// ==== test/tb_exu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exu_config.svh"

module tb_exu_top
  import exu_op_pkg::*;
  import exu_bus_pkg::*;
();

  `include "tb_exu_vectors.svh"

  localparam int CLK_HALF   = 20;
  localparam int DRIVE_DLY  = 5;
  localparam int SAMPLE_DLY = 25;  // lands 10 ns before the next edge
  localparam int WAIT_LIMIT = 8;
  localparam logic [`TRAP_LEN-1:0] TRAP_VAL = 8'h3c;
  localparam logic [`HISLEN-1:0]   HIST_VAL = 8'h5a;

  logic              clk_i;
  logic              rst_i;
  logic              valid_i;
  logic              stall_i;
  id_ex_bus_t        id_ex_i;
  pdt_info_t         pdt_i;
  ex_mem_bus_t       ex_mem_o;
  logic              ex_mem_valid_o;
  bpu_update_t       bpu_upd_o;
  logic              bpu_upd_valid_o;
  redirect_t         redirect_o;
  logic [`XLEN-1:0]  alu_fwd_o;
  logic [`CNT_W-1:0] branch_cnt_o;
  logic [`CNT_W-1:0] correct_cnt_o;

  string  test_name;
  integer seed;
  int     cf_cnt;   // accepted jumps and branches
  int     ok_cnt;   // of those, correctly predicted

  exu_top exu_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_val(input string what, input logic [`XLEN-1:0] exp,
                           input logic [`XLEN-1:0] got);
    assert (got === exp) else begin
      $display("** Error %0s: %0s expected %h, actual %h", test_name, what, exp, got);
      stop_run();
    end
  endtask

  // reference for the register-register rows
  function automatic logic [`XLEN-1:0] alu_model(input alu_op_e op,
                                                 input logic [`XLEN-1:0] a, b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SRA:  return (a >> b[4:0]) | ({`XLEN{a[`XLEN-1]}} << (`XLEN - b[4:0])); // sign fill
      default:  return a + b;
    endcase
  endfunction

  task automatic drive_row(input vec_t v);
    id_ex_i          = '0;
    id_ex_i.pc       = v.pc;
    id_ex_i.inst     = 32'h00000013;
    id_ex_i.rd_idx   = 5'd1;
    id_ex_i.rs1_data = v.rs1;
    id_ex_i.rs2_data = v.rs2;
    id_ex_i.imm      = v.imm;
    id_ex_i.exc_op   = v.exc;
    id_ex_i.alu_op   = v.op;
    id_ex_i.trap     = TRAP_VAL;
    pdt_i.pdt_taken  = v.pdt;
    pdt_i.which_pdt  = v.pdt;
    pdt_i.history    = HIST_VAL;
    pdt_i.pdt_tag    = v.tag;
  endtask

  task automatic check_comb(input vec_t v);
    check_val("alu_fwd_o", v.res, alu_fwd_o);
    check_val("redirect valid", v.redir, redirect_o.valid);
    if (v.redir)
      check_val("redirect target", v.target, redirect_o.target);
  endtask

  // one edge after acceptance
  task automatic check_reg(input vec_t v);
    check_val("ex_mem_valid_o", 1, ex_mem_valid_o);
    check_val("ex_mem alu_res", v.res, ex_mem_o.alu_res);
    check_val("ex_mem pc", v.pc, ex_mem_o.pc);
    check_val("ex_mem rs2_data", v.rs2, ex_mem_o.rs2_data);
    check_val("ex_mem exc_op", v.exc, ex_mem_o.exc_op);
    check_val("ex_mem trap", TRAP_VAL, ex_mem_o.trap);
    check_val("bpu_upd_valid_o", v.upd, bpu_upd_valid_o);
    if (v.upd) begin
      check_val("update pc", v.pc, bpu_upd_o.pc);
      check_val("update taken", v.taken, bpu_upd_o.taken);
      check_val("update correct", v.correct, bpu_upd_o.correct);
      check_val("update jump_type", v.jt, bpu_upd_o.jump_type);
      check_val("update which_pdt", v.pdt, bpu_upd_o.which_pdt);
      check_val("update history", HIST_VAL, bpu_upd_o.history);
    end
  endtask

  initial begin
    vec_t        v;
    vec_t        s;
    ex_mem_bus_t held_mem;
    bpu_update_t held_upd;
    logic        held_upd_valid;
    int          waited;

    seed = 1;
    cf_cnt = 0;
    ok_cnt = 0;
    rst_i = 1'b1;
    valid_i = 1'b0;
    stall_i = 1'b0;
    id_ex_i = '0;
    pdt_i = '0;
    load_vectors();

    repeat (2) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;
    test_name = "reset";
    check_val("ex_mem_valid_o", 0, ex_mem_valid_o);
    check_val("bpu_upd_valid_o", 0, bpu_upd_valid_o);
    check_val("redirect valid", 0, redirect_o.valid);
    check_val("branch_cnt_o", 0, branch_cnt_o);
    check_val("correct_cnt_o", 0, correct_cnt_o);

    for (int i = 0; i < vec_q.size() - 1; i++) begin
      v = vec_q[i];
      test_name = name_q[i];
      if (v.exc == EXC_OPREG) begin
        v.rs1 = $random(seed);
        v.rs2 = $random(seed);
        v.res = alu_model(v.op, v.rs1, v.rs2);
      end
      drive_row(v);
      valid_i = 1'b1;
      #SAMPLE_DLY;
      check_comb(v);
      @(posedge clk_i);
      #DRIVE_DLY;
      check_reg(v);
      if (v.upd) begin
        cf_cnt++;
        if (v.correct) ok_cnt++;
      end
    end

    // hold a mispredicted branch behind a three-cycle stall
    s = vec_q[vec_q.size() - 1];
    test_name = name_q[vec_q.size() - 1];
    held_mem = ex_mem_o;
    held_upd = bpu_upd_o;
    held_upd_valid = bpu_upd_valid_o;
    stall_i = 1'b1;
    drive_row(s);
    for (int k = 0; k < 3; k++) begin
      #SAMPLE_DLY;
      check_val("redirect valid in stall", 0, redirect_o.valid);
      @(posedge clk_i);
      #DRIVE_DLY;
      assert (ex_mem_o === held_mem) else begin
        $display("** Error %0s: ex_mem_o expected %h, actual %h", test_name, held_mem, ex_mem_o);
        stop_run();
      end
      assert (bpu_upd_o === held_upd) else begin
        $display("** Error %0s: bpu_upd_o expected %h, actual %h", test_name, held_upd,
                 bpu_upd_o);
        stop_run();
      end
      check_val("ex_mem_valid_o held", 1, ex_mem_valid_o);
      check_val("bpu_upd_valid_o held", held_upd_valid, bpu_upd_valid_o);
      check_val("branch_cnt_o held", cf_cnt, branch_cnt_o);
      check_val("correct_cnt_o held", ok_cnt, correct_cnt_o);
    end
    stall_i = 1'b0;
    #SAMPLE_DLY;
    check_comb(s);

    waited = 0;
    do begin
      @(posedge clk_i);
      #DRIVE_DLY;
      waited++;
    end while (ex_mem_o.pc !== s.pc && waited < WAIT_LIMIT);
    assert (ex_mem_o.pc === s.pc) else begin
      $display("timeout: the stalled branch never reached the EX/MEM register");
      stop_run();
    end
    check_val("cycles to accept", 1, waited);
    valid_i = 1'b0;
    check_reg(s);
    cf_cnt++;  // mispredicted, so no correct count

    @(posedge clk_i);
    #DRIVE_DLY;
    check_val("ex_mem_valid_o after", 0, ex_mem_valid_o);
    check_val("bpu_upd_valid_o after", 0, bpu_upd_valid_o);

    test_name = "counters";
    check_val("branch_cnt_o", cf_cnt, branch_cnt_o);
    check_val("correct_cnt_o", ok_cnt, correct_cnt_o);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+source
+incdir+test
source/exu_op_pkg.sv
source/exu_bus_pkg.sv
source/operand_mux.sv
source/alu.sv
source/branch_resolve.sv
source/pipe_reg.sv
source/pred_stats.sv
source/exu_top.sv
test/tb_exu_top.sv
